//--- source/core_cfg.svh
////////////////////
// Event-control configuration
// Widths, CSR bit positions and interrupt line numbers
////////////////////
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data width of CSR commands and interrupt vector
`define CORE_XLEN 32
// Width of the interrupt identifier
`define CORE_IRQ_ID_W 5

// Standard machine interrupts (software, timer, external)
`define CORE_IRQ_MSI 3
`define CORE_IRQ_MTI 7
`define CORE_IRQ_MEI 11
// Fast interrupts occupy lines 16 up to 31
`define CORE_IRQ_FAST_LO 16

// mstatus bit positions
`define CORE_MSTATUS_MIE 3
`define CORE_MSTATUS_MPIE 7

// Implemented lines, 31:16 plus 11, 7 and 3
`define CORE_IRQ_VALID_MASK 32'hFFFF_0888
`endif

//--- source/core_csr_pkg.sv
////////////////////
// Architectural state types
// CSR command encodings and interrupt status
////////////////////
`include "core_cfg.svh"

package core_csr_pkg;

  // CSR opcode carried by a command
  typedef enum logic [1:0] {
    CSR_OP_WRITE = 2'b00,
    CSR_OP_SET   = 2'b01,
    CSR_OP_CLEAR = 2'b10
  } csr_op_e;

  // Only mstatus and mie are reachable
  typedef enum logic {
    CSR_MSTATUS = 1'b0,
    CSR_MIE     = 1'b1
  } csr_addr_e;

  // CSR command, acted on while valid is high
  typedef struct packed {
    logic                  valid;
    csr_op_e               op;
    csr_addr_e             addr;
    logic [`CORE_XLEN-1:0] wdata;
  } csr_cmd_t;

  // Interrupt unit result towards the controller
  typedef struct packed {
    logic                      req;
    logic                      wake;
    logic [`CORE_IRQ_ID_W-1:0] id;
  } irq_status_t;

endpackage

//--- source/core_ctrl_pkg.sv
////////////////////
// Control types
// Controller states and debug status
////////////////////

package core_ctrl_pkg;

  // Controller FSM states
  typedef enum logic [2:0] {
    RESET        = 3'd0,
    BOOT         = 3'd1,
    FUNCTIONAL   = 3'd2,
    SLEEP        = 3'd3,
    DEBUG_HALTED = 3'd4
  } ctrl_state_e;

  // Debug unit result towards the controller
  typedef struct packed {
    // Halt request waiting to be taken
    logic pending;
    // No halt seen since reset
    logic havereset;
  } debug_status_t;

endpackage

//--- source/irq_unit.sv
////////////////////
// Interrupt unit
// Pending lines, mie and mstatus enables, fixed-priority winner select
////////////////////
`timescale 1ns/100ps
`include "core_cfg.svh"

module irq_unit (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [`CORE_XLEN-1:0]     irq_i,
  input  core_csr_pkg::csr_cmd_t    csr_cmd_i,
  input  logic                      irq_take_i,
  input  logic                      mret_i,
  output core_csr_pkg::irq_status_t irq_status_o
);

  // Registered interrupt lines
  logic [`CORE_XLEN-1:0]     mip_q;
  // Per-line enables, only implemented bits
  logic [`CORE_XLEN-1:0]     mie_q;
  logic [`CORE_XLEN-1:0]     mie_d;
  // Global enable and its saved copy
  logic                      mstatus_mie_q;
  logic                      mstatus_mpie_q;
  logic                      mstatus_mie_d;
  logic                      mstatus_mpie_d;
  // Command decode
  logic                      csr_mstatus_sel;
  logic                      csr_mie_sel;
  // Pending and enabled lines
  logic [`CORE_XLEN-1:0]     irq_pend_en;
  logic [`CORE_IRQ_ID_W-1:0] irq_id;

  // Apply a write, set or clear to a single bit
  function automatic logic csr_bit_update(core_csr_pkg::csr_op_e op, logic old_bit,
                                          logic wbit);
    logic res;
    case (op)
      core_csr_pkg::CSR_OP_WRITE: res = wbit;
      core_csr_pkg::CSR_OP_SET:   res = old_bit | wbit;
      core_csr_pkg::CSR_OP_CLEAR: res = old_bit & ~wbit;
      default:                    res = old_bit;
    endcase
    return res;
  endfunction

  assign csr_mstatus_sel = csr_cmd_i.valid && (csr_cmd_i.addr == core_csr_pkg::CSR_MSTATUS);
  assign csr_mie_sel     = csr_cmd_i.valid && (csr_cmd_i.addr == core_csr_pkg::CSR_MIE);

  ////////////////////
  // Enable state
  ////////////////////

  // mie update, unimplemented bits forced to zero
  always_comb begin
    mie_d = mie_q;
    if (csr_mie_sel) begin
      case (csr_cmd_i.op)
        core_csr_pkg::CSR_OP_WRITE: mie_d = csr_cmd_i.wdata;
        core_csr_pkg::CSR_OP_SET:   mie_d = mie_q | csr_cmd_i.wdata;
        core_csr_pkg::CSR_OP_CLEAR: mie_d = mie_q & ~csr_cmd_i.wdata;
        default:                    mie_d = mie_q;
      endcase
    end
    mie_d = mie_d & `CORE_IRQ_VALID_MASK;
  end

  // mstatus update; take and mret override a CSR command
  always_comb begin
    mstatus_mie_d  = mstatus_mie_q;
    mstatus_mpie_d = mstatus_mpie_q;
    if (irq_take_i) begin
      // Save global enable, then mask further interrupts
      mstatus_mpie_d = mstatus_mie_q;
      mstatus_mie_d  = 1'b0;
    end else if (mret_i) begin
      mstatus_mie_d  = mstatus_mpie_q;
      mstatus_mpie_d = 1'b1;
    end else if (csr_mstatus_sel) begin
      mstatus_mie_d  = csr_bit_update(csr_cmd_i.op, mstatus_mie_q,
                                      csr_cmd_i.wdata[`CORE_MSTATUS_MIE]);
      mstatus_mpie_d = csr_bit_update(csr_cmd_i.op, mstatus_mpie_q,
                                      csr_cmd_i.wdata[`CORE_MSTATUS_MPIE]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mip_q          <= '0;
      mie_q          <= '0;
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else begin
      // Level lines sampled every cycle
      mip_q          <= irq_i & `CORE_IRQ_VALID_MASK;
      mie_q          <= mie_d;
      mstatus_mie_q  <= mstatus_mie_d;
      mstatus_mpie_q <= mstatus_mpie_d;
    end
  end

  ////////////////////
  // Priority select
  ////////////////////

  assign irq_pend_en = mip_q & mie_q;

  // Lowest priority first, later hits overwrite
  always_comb begin
    irq_id = '0;
    if (irq_pend_en[`CORE_IRQ_MTI])
      irq_id = `CORE_IRQ_ID_W'(`CORE_IRQ_MTI);
    if (irq_pend_en[`CORE_IRQ_MSI])
      irq_id = `CORE_IRQ_ID_W'(`CORE_IRQ_MSI);
    if (irq_pend_en[`CORE_IRQ_MEI])
      irq_id = `CORE_IRQ_ID_W'(`CORE_IRQ_MEI);
    // Fast lines, highest number wins
    for (int i = `CORE_IRQ_FAST_LO; i < `CORE_XLEN; i++) begin
      if (irq_pend_en[i])
        irq_id = `CORE_IRQ_ID_W'(i);
    end
  end

  // Wake ignores the global enable
  assign irq_status_o.wake = |irq_pend_en;
  assign irq_status_o.req  = (|irq_pend_en) && mstatus_mie_q;
  assign irq_status_o.id   = irq_id;

  // Winner is always a pending and enabled line
  a_req_id_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    irq_status_o.req |-> (mip_q[irq_status_o.id] && mie_q[irq_status_o.id]));

endmodule

//--- source/debug_unit.sv
////////////////////
// Debug unit
// Sticky halt request and have-reset flag
////////////////////
`timescale 1ns/100ps

module debug_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        debug_req_i,
  input  logic                        debug_enter_i,
  output core_ctrl_pkg::debug_status_t debug_status_o
);

  // Request waiting for the controller
  logic pending_q;
  // Cleared by the first halt
  logic havereset_q;

  ////////////////////
  // Request capture
  ////////////////////

  // Pulse or level request held until the halt is entered
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (debug_enter_i) begin
      // Request consumed by the halt
      pending_q <= 1'b0;
    end else if (debug_req_i) begin
      pending_q <= 1'b1;
    end
  end

  // Have-reset flag
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      havereset_q <= 1'b1;
    end else if (debug_enter_i) begin
      havereset_q <= 1'b0;
    end
  end

  assign debug_status_o.pending   = pending_q;
  assign debug_status_o.havereset = havereset_q;

  // Request only drops when the controller enters halt
  a_pending_held: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(pending_q) |-> $past(debug_enter_i));

endmodule

//--- source/core_ctrl_fsm.sv
////////////////////
// Controller FSM
// Combines interrupt and debug results into acknowledge and run state
////////////////////
`timescale 1ns/100ps
`include "core_cfg.svh"

module core_ctrl_fsm (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          fetch_enable_i,
  input  core_csr_pkg::irq_status_t     irq_status_i,
  input  core_ctrl_pkg::debug_status_t  debug_status_i,
  input  logic                          dret_i,
  input  logic                          wfi_i,
  output logic                          irq_take_o,
  output logic                          debug_enter_o,
  output logic                          irq_ack_o,
  output logic [`CORE_IRQ_ID_W-1:0]     irq_id_o,
  output logic                          debug_havereset_o,
  output logic                          debug_running_o,
  output logic                          debug_halted_o,
  output logic                          core_sleep_o
);

  core_ctrl_pkg::ctrl_state_e state_q;
  core_ctrl_pkg::ctrl_state_e state_d;

  // Registered acknowledge
  logic                      irq_ack_q;
  logic [`CORE_IRQ_ID_W-1:0] irq_id_q;

  ////////////////////
  // Next state
  ////////////////////

  // Priority in FUNCTIONAL is debug, then interrupt, then sleep
  always_comb begin
    state_d       = state_q;
    irq_take_o    = 1'b0;
    debug_enter_o = 1'b0;
    case (state_q)
      core_ctrl_pkg::RESET: begin
        // Wait for fetch enable
        if (fetch_enable_i)
          state_d = core_ctrl_pkg::BOOT;
      end
      core_ctrl_pkg::BOOT: begin
        state_d = core_ctrl_pkg::FUNCTIONAL;
      end
      core_ctrl_pkg::FUNCTIONAL: begin
        if (debug_status_i.pending) begin
          debug_enter_o = 1'b1;
          state_d       = core_ctrl_pkg::DEBUG_HALTED;
        end else if (irq_status_i.req) begin
          // Stay running, trap handled in place
          irq_take_o = 1'b1;
        end else if (wfi_i && !irq_status_i.wake) begin
          state_d = core_ctrl_pkg::SLEEP;
        end
      end
      core_ctrl_pkg::SLEEP: begin
        // Any enabled line wakes, even with global enable off
        if (irq_status_i.wake || debug_status_i.pending)
          state_d = core_ctrl_pkg::FUNCTIONAL;
      end
      core_ctrl_pkg::DEBUG_HALTED: begin
        if (dret_i)
          state_d = core_ctrl_pkg::FUNCTIONAL;
      end
      default: begin
        state_d = core_ctrl_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= core_ctrl_pkg::RESET;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // Acknowledge
  ////////////////////

  // One cycle after the take
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_ack_q <= 1'b0;
      irq_id_q  <= '0;
    end else begin
      irq_ack_q <= irq_take_o;
      if (irq_take_o)
        irq_id_q <= irq_status_i.id;
    end
  end

  assign irq_ack_o = irq_ack_q;
  assign irq_id_o  = irq_id_q;

  // Run state from the current state
  assign debug_havereset_o = debug_status_i.havereset;
  assign debug_running_o   = (state_q == core_ctrl_pkg::FUNCTIONAL) ||
                             (state_q == core_ctrl_pkg::SLEEP);
  assign debug_halted_o    = (state_q == core_ctrl_pkg::DEBUG_HALTED);
  assign core_sleep_o      = (state_q == core_ctrl_pkg::SLEEP);

  // Halted and running are exclusive
  a_run_halt_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(debug_halted_o && debug_running_o));

  // Acknowledge follows a FUNCTIONAL cycle
  a_ack_after_func: assert property (@(posedge clk_i) disable iff (reset_i)
    irq_ack_o |-> $past(state_q == core_ctrl_pkg::FUNCTIONAL));

endmodule

//--- source/core_event_top.sv
////////////////////
// Event-control top
// Interrupt unit, debug unit and controller FSM
////////////////////
`timescale 1ns/100ps
`include "core_cfg.svh"

module core_event_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Interrupts
  input  logic [`CORE_XLEN-1:0]     irq_i,
  output logic                      irq_ack_o,
  output logic [`CORE_IRQ_ID_W-1:0] irq_id_o,
  // Debug
  input  logic                      debug_req_i,
  output logic                      debug_havereset_o,
  output logic                      debug_running_o,
  output logic                      debug_halted_o,
  // Core control and retire strobes
  input  logic                      fetch_enable_i,
  input  core_csr_pkg::csr_cmd_t    csr_cmd_i,
  input  logic                      mret_i,
  input  logic                      dret_i,
  input  logic                      wfi_i,
  output logic                      core_sleep_o
);

  core_csr_pkg::irq_status_t    irq_status;
  core_ctrl_pkg::debug_status_t debug_status;
  // Controller strobes back to the units
  logic                         irq_take;
  logic                         debug_enter;

  irq_unit irq_unit_i (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .irq_i        ( irq_i      ),
    .csr_cmd_i    ( csr_cmd_i  ),
    .irq_take_i   ( irq_take   ),
    .mret_i       ( mret_i     ),
    .irq_status_o ( irq_status )
  );

  debug_unit debug_unit_i (
    .clk_i          ( clk_i        ),
    .reset_i        ( reset_i      ),
    .debug_req_i    ( debug_req_i  ),
    .debug_enter_i  ( debug_enter  ),
    .debug_status_o ( debug_status )
  );

  core_ctrl_fsm ctrl_fsm_i (
    .clk_i             ( clk_i             ),
    .reset_i           ( reset_i           ),
    .fetch_enable_i    ( fetch_enable_i    ),
    .irq_status_i      ( irq_status        ),
    .debug_status_i    ( debug_status      ),
    .dret_i            ( dret_i            ),
    .wfi_i             ( wfi_i             ),
    .irq_take_o        ( irq_take          ),
    .debug_enter_o     ( debug_enter       ),
    .irq_ack_o         ( irq_ack_o         ),
    .irq_id_o          ( irq_id_o          ),
    .debug_havereset_o ( debug_havereset_o ),
    .debug_running_o   ( debug_running_o   ),
    .debug_halted_o    ( debug_halted_o    ),
    .core_sleep_o      ( core_sleep_o      )
  );

endmodule

//--- tb/tb_core_event.sv
////////////////////
// Event-control testbench
// Drives reset, interrupts, CSR commands, debug and sleep
////////////////////
`timescale 1ns/100ps
`include "core_cfg.svh"

module tb_core_event;

  localparam int CLK_PERIOD  = 8;
  localparam int IRQ_VECTORS = 20;
  // Cycle budget of each test in run order
  localparam int RUN_CYCLES  = 30 + IRQ_VECTORS * 9 + 25 + 35 + 25;
  localparam int WATCHDOG_NS = (RUN_CYCLES + 200) * CLK_PERIOD;

  logic                      clk_i;
  logic                      reset_i;
  logic [`CORE_XLEN-1:0]     irq_i;
  logic                      debug_req_i;
  logic                      fetch_enable_i;
  core_csr_pkg::csr_cmd_t    csr_cmd_i;
  logic                      mret_i;
  logic                      dret_i;
  logic                      wfi_i;
  logic                      irq_ack_o;
  logic [`CORE_IRQ_ID_W-1:0] irq_id_o;
  logic                      debug_havereset_o;
  logic                      debug_running_o;
  logic                      debug_halted_o;
  logic                      core_sleep_o;

  // Stimulus flags that each arm one assertion
  logic                      fetch_seen;
  logic                      ack_expect;
  logic                      no_ack_expect;
  logic                      halt_expect;
  logic                      sleep_expect;
  logic                      wake_expect;
  logic [`CORE_IRQ_ID_W-1:0] exp_id;
  // Enables as the test expects them
  logic [`CORE_XLEN-1:0]     mie_model;
  int                        acks_since_mret;
  int                        err_cnt;
  int                        test_cnt;
  int                        test_err_start;

  core_event_top DUT (
    .clk_i             ( clk_i             ),
    .reset_i           ( reset_i           ),
    .irq_i             ( irq_i             ),
    .irq_ack_o         ( irq_ack_o         ),
    .irq_id_o          ( irq_id_o          ),
    .debug_req_i       ( debug_req_i       ),
    .debug_havereset_o ( debug_havereset_o ),
    .debug_running_o   ( debug_running_o   ),
    .debug_halted_o    ( debug_halted_o    ),
    .fetch_enable_i    ( fetch_enable_i    ),
    .csr_cmd_i         ( csr_cmd_i         ),
    .mret_i            ( mret_i            ),
    .dret_i            ( dret_i            ),
    .wfi_i             ( wfi_i             ),
    .core_sleep_o      ( core_sleep_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic report_error(string msg);
    $display("error %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  // Reference winner with fast lines high to low ahead of 11, 3 and 7
  function automatic logic [`CORE_IRQ_ID_W-1:0] expected_irq_id(logic [`CORE_XLEN-1:0] pend);
    logic [`CORE_IRQ_ID_W-1:0] id;
    logic                      found;
    id    = '0;
    found = 1'b0;
    for (int i = `CORE_XLEN - 1; i >= `CORE_IRQ_FAST_LO; i--) begin
      if (!found && pend[i]) begin
        id    = `CORE_IRQ_ID_W'(i);
        found = 1'b1;
      end
    end
    if (!found && pend[`CORE_IRQ_MEI]) begin
      id    = `CORE_IRQ_ID_W'(`CORE_IRQ_MEI);
      found = 1'b1;
    end
    if (!found && pend[`CORE_IRQ_MSI]) begin
      id    = `CORE_IRQ_ID_W'(`CORE_IRQ_MSI);
      found = 1'b1;
    end
    if (!found && pend[`CORE_IRQ_MTI])
      id = `CORE_IRQ_ID_W'(`CORE_IRQ_MTI);
    return id;
  endfunction

  ////////////////////
  // Checkers
  ////////////////////

  // Acknowledges seen since the last mret
  always @(posedge clk_i) begin
    if (reset_i || mret_i)
      acks_since_mret <= 0;
    else if (irq_ack_o)
      acks_since_mret <= acks_since_mret + 1;
  end

  a_reset_outputs: assert property (@(posedge clk_i) $fell(reset_i) |->
    (!irq_ack_o && irq_id_o == '0 && !debug_running_o && !debug_halted_o &&
     !core_sleep_o && debug_havereset_o))
    else report_error("outputs not in reset state");

  a_idle_before_fetch: assert property (@(posedge clk_i) disable iff (reset_i)
    !fetch_seen |-> !debug_running_o)
    else report_error("debug_running_o high before fetch enable");

  // BOOT sits between RESET and FUNCTIONAL
  a_boot_delay: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(fetch_enable_i) |-> !debug_running_o ##1 !debug_running_o ##1 debug_running_o)
    else report_error("debug_running_o not high 2 cycles after fetch enable");

  // Ack two edges after a line or enable change
  a_ack_timing: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_expect |-> ##1 !irq_ack_o ##1 (irq_ack_o && irq_id_o == exp_id))
    else report_error($sformatf("irq_ack_o or irq_id_o wrong, expected id %0d", exp_id));

  a_no_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    no_ack_expect |-> !irq_ack_o)
    else report_error("irq_ack_o high while no interrupt may be taken");

  a_one_ack_per_trap: assert property (@(posedge clk_i) disable iff (reset_i)
    irq_ack_o |-> acks_since_mret == 0)
    else report_error("second irq_ack_o without mret");

  a_halt_timing: assert property (@(posedge clk_i) disable iff (reset_i)
    halt_expect |-> ##1 !debug_halted_o ##1
      (debug_halted_o && !debug_running_o && !debug_havereset_o))
    else report_error("debug halt not entered 2 cycles after request");

  a_dret_resume: assert property (@(posedge clk_i) disable iff (reset_i)
    (dret_i && debug_halted_o) |=> (debug_running_o && !debug_halted_o))
    else report_error("dret_i did not resume the core");

  a_sleep_enter: assert property (@(posedge clk_i) disable iff (reset_i)
    sleep_expect |=> core_sleep_o)
    else report_error("wfi_i did not raise core_sleep_o");

  // Still asleep on the edge that sees the line
  a_sleep_wake: assert property (@(posedge clk_i) disable iff (reset_i)
    wake_expect |-> core_sleep_o ##1 core_sleep_o ##1 !core_sleep_o)
    else report_error("enabled line did not wake the core");

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic step_cycle(int n = 1);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // One-cycle CSR command
  task automatic csr_apply(core_csr_pkg::csr_op_e op, core_csr_pkg::csr_addr_e addr,
                           logic [`CORE_XLEN-1:0] wdata);
    csr_cmd_i.valid = 1'b1;
    csr_cmd_i.op    = op;
    csr_cmd_i.addr  = addr;
    csr_cmd_i.wdata = wdata;
    step_cycle();
    csr_cmd_i.valid = 1'b0;
  endtask

  task automatic pulse_mret();
    mret_i = 1'b1;
    step_cycle();
    mret_i = 1'b0;
  endtask

  task automatic finish_test(string name);
    test_cnt++;
    $display("test %s finished with %0d errors", name, err_cnt - test_err_start);
    test_err_start = err_cnt;
  endtask

  task automatic check_reset_state();
    step_cycle(4);
    fetch_enable_i = 1'b1;
    fetch_seen     = 1'b1;
    step_cycle(5);
    finish_test("reset_state");
  endtask

  task automatic sweep_irq_priority();
    logic [`CORE_XLEN-1:0] vec;
    mie_model = '1 & `CORE_IRQ_VALID_MASK;
    csr_apply(core_csr_pkg::CSR_OP_WRITE, core_csr_pkg::CSR_MIE, '1);
    csr_apply(core_csr_pkg::CSR_OP_SET, core_csr_pkg::CSR_MSTATUS, 1 << `CORE_MSTATUS_MIE);
    step_cycle();
    for (int n = 0; n < IRQ_VECTORS; n++) begin
      vec = $urandom & `CORE_IRQ_VALID_MASK;
      // Every other vector only on the standard lines
      if (n % 2 == 1)
        vec = vec & `CORE_IRQ_VALID_MASK & 32'h0000_ffff;
      if (vec == '0)
        vec[`CORE_IRQ_MTI] = 1'b1;
      exp_id     = expected_irq_id(vec & mie_model);
      irq_i      = vec;
      ack_expect = 1'b1;
      step_cycle();
      ack_expect = 1'b0;
      // Lines stay high while MIE is clear
      step_cycle(4);
      irq_i = '0;
      step_cycle(2);
      // Restores MIE for the next vector
      pulse_mret();
    end
    step_cycle();
    finish_test("irq_priority");
  endtask

  task automatic mask_irq_by_csr();
    mie_model[`CORE_IRQ_MEI] = 1'b0;
    csr_apply(core_csr_pkg::CSR_OP_CLEAR, core_csr_pkg::CSR_MIE, 1 << `CORE_IRQ_MEI);
    step_cycle();
    irq_i         = 1 << `CORE_IRQ_MEI;
    no_ack_expect = 1'b1;
    step_cycle(5);
    no_ack_expect = 1'b0;
    // Set command re-enables the waiting line
    mie_model[`CORE_IRQ_MEI] = 1'b1;
    exp_id     = expected_irq_id(irq_i & mie_model);
    ack_expect = 1'b1;
    csr_apply(core_csr_pkg::CSR_OP_SET, core_csr_pkg::CSR_MIE, 1 << `CORE_IRQ_MEI);
    ack_expect = 1'b0;
    step_cycle(4);
    irq_i = '0;
    step_cycle(2);
    pulse_mret();
    step_cycle();
    finish_test("csr_mask");
  endtask

  task automatic halt_and_resume();
    // Plain single-cycle request
    debug_req_i = 1'b1;
    halt_expect = 1'b1;
    step_cycle();
    debug_req_i = 1'b0;
    halt_expect = 1'b0;
    step_cycle(3);
    dret_i = 1'b1;
    step_cycle();
    dret_i = 1'b0;
    step_cycle(2);
    // Request beats an interrupt raised in the same cycle
    irq_i         = 1 << `CORE_IRQ_MTI;
    debug_req_i   = 1'b1;
    halt_expect   = 1'b1;
    no_ack_expect = 1'b1;
    step_cycle();
    debug_req_i = 1'b0;
    halt_expect = 1'b0;
    step_cycle(4);
    no_ack_expect = 1'b0;
    // Waiting line taken once the core resumes
    exp_id        = expected_irq_id(irq_i & mie_model);
    dret_i        = 1'b1;
    ack_expect    = 1'b1;
    step_cycle();
    dret_i     = 1'b0;
    ack_expect = 1'b0;
    step_cycle(4);
    irq_i = '0;
    step_cycle(2);
    pulse_mret();
    step_cycle();
    finish_test("debug");
  endtask

  task automatic sleep_and_wake();
    csr_apply(core_csr_pkg::CSR_OP_CLEAR, core_csr_pkg::CSR_MSTATUS, 1 << `CORE_MSTATUS_MIE);
    step_cycle();
    wfi_i        = 1'b1;
    sleep_expect = 1'b1;
    step_cycle();
    wfi_i        = 1'b0;
    sleep_expect = 1'b0;
    step_cycle(3);
    // Enabled fast line with global enable off
    irq_i         = 1 << `CORE_IRQ_FAST_LO;
    wake_expect   = 1'b1;
    no_ack_expect = 1'b1;
    step_cycle();
    wake_expect = 1'b0;
    step_cycle(5);
    no_ack_expect = 1'b0;
    irq_i         = '0;
    step_cycle(2);
    finish_test("sleep");
  endtask

  initial begin
    void'($urandom(32'hfd50));
    reset_i        = 1'b1;
    irq_i          = '0;
    debug_req_i    = 1'b0;
    fetch_enable_i = 1'b0;
    csr_cmd_i      = '0;
    mret_i         = 1'b0;
    dret_i         = 1'b0;
    wfi_i          = 1'b0;
    fetch_seen     = 1'b0;
    ack_expect     = 1'b0;
    no_ack_expect  = 1'b0;
    halt_expect    = 1'b0;
    sleep_expect   = 1'b0;
    wake_expect    = 1'b0;
    exp_id         = '0;
    mie_model      = '0;
    err_cnt        = 0;
    test_cnt       = 0;
    test_err_start = 0;
    step_cycle(10);
    reset_i = 1'b0;
    check_reset_state();
    sweep_irq_priority();
    mask_irq_by_csr();
    halt_and_resume();
    sleep_and_wake();
    // Let the last sequences complete
    step_cycle(5);
    $display("tests run %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not complete within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- sources.f
+incdir+source
source/core_csr_pkg.sv
source/core_ctrl_pkg.sv
source/irq_unit.sv
source/debug_unit.sv
source/core_ctrl_fsm.sv
source/core_event_top.sv
tb/tb_core_event.sv
